//--- hw/axil_sram_pkg.sv
`default_nettype none

package axil_sram_pkg;

  // ======================================
  // widths
  // ======================================
  localparam int axil_addr_w = 12;  // byte address on the bus
  localparam int axil_data_w = 16;
  localparam int addr_lsb    = 1;   // byte offset bits dropped
  localparam int sram_addr_w = axil_addr_w - addr_lsb;
  localparam int sram_depth  = 1 << sram_addr_w;

  localparam logic [1:0] resp_okay = 2'b00;

  typedef logic [axil_addr_w-1:0]   axil_addr_t;
  typedef logic [axil_data_w-1:0]   axil_data_t;
  typedef logic [axil_data_w/8-1:0] axil_strb_t;
  typedef logic [1:0]               axil_resp_t;
  typedef logic [sram_addr_w-1:0]   sram_addr_t;

  // ======================================
  // sram command, 30 bits
  // ======================================
  typedef struct packed {
    logic       we;     // write when set
    sram_addr_t addr;
    axil_data_t wdata;
    axil_strb_t wstrb;
  } sram_cmd_t;

  // adapter state machines
  typedef enum logic [1:0] {
    rd_idle,
    rd_cmd,
    rd_resp
  } rd_state_t;

  typedef enum logic [1:0] {
    wr_idle,
    wr_cmd,
    wr_bresp,
    wr_done
  } wr_state_t;

endpackage

`default_nettype wire

//--- hw/axil_sram_rd.sv
`default_nettype none
`timescale 1ns/1ps

module axil_sram_rd (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      arvalid,
  output logic                      arready,
  input  axil_sram_pkg::axil_addr_t araddr,

  output logic                      rvalid,
  input  logic                      rready,
  output axil_sram_pkg::axil_data_t rdata,
  output axil_sram_pkg::axil_resp_t rresp,

  output logic                      cmd_valid,
  input  logic                      cmd_ready,
  output axil_sram_pkg::sram_cmd_t  cmd,

  input  logic                      resp_valid,
  output logic                      resp_ready,
  input  axil_sram_pkg::axil_data_t resp_data
);
  import axil_sram_pkg::*;

  rd_state_t  state;
  sram_addr_t addr_q;  // word address of the pending read

  // ======================================
  // control
  // ======================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= rd_idle;
      arready <= 1'b0;
    end else begin
      case (state)
        rd_idle: begin
          if (arvalid && arready) begin
            arready <= 1'b0;
            state   <= rd_cmd;
          end else begin
            arready <= 1'b1;  // comes up one cycle out of reset
          end
        end
        rd_cmd: begin
          if (cmd_ready) state <= rd_resp;
        end
        rd_resp: begin
          if (rvalid && rready) begin
            arready <= 1'b1;
            state   <= rd_idle;
          end
        end
        default: state <= rd_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) addr_q <= araddr[axil_addr_w-1:addr_lsb];
  end

  assign cmd_valid = (state == rd_cmd);
  assign cmd       = '{we: 1'b0, addr: addr_q, wdata: '0, wstrb: '0};

  // response goes straight through to R
  assign rvalid     = resp_valid;
  assign rdata      = resp_data;
  assign rresp      = resp_okay;
  assign resp_ready = rready;

  a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

endmodule

`default_nettype wire

//--- hw/axil_sram_top.sv
`default_nettype none
`timescale 1ns/1ps

module axil_sram_top (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      arvalid,
  output logic                      arready,
  input  axil_sram_pkg::axil_addr_t araddr,
  output logic                      rvalid,
  input  logic                      rready,
  output axil_sram_pkg::axil_data_t rdata,
  output axil_sram_pkg::axil_resp_t rresp,

  input  logic                      awvalid,
  output logic                      awready,
  input  axil_sram_pkg::axil_addr_t awaddr,
  input  logic                      wvalid,
  output logic                      wready,
  input  axil_sram_pkg::axil_data_t wdata,
  input  axil_sram_pkg::axil_strb_t wstrb,
  output logic                      bvalid,
  input  logic                      bready,
  output axil_sram_pkg::axil_resp_t bresp
);
  import axil_sram_pkg::*;

  logic       rd_req_valid, rd_req_ready;
  sram_cmd_t  rd_req;
  logic       wr_req_valid, wr_req_ready;
  sram_cmd_t  wr_req;
  logic       mem_req_valid, mem_req_ready;
  sram_cmd_t  mem_req;
  logic       resp_valid, resp_ready;
  axil_data_t resp_data;

  axil_sram_rd u_rd (
    .clk, .rst_n, .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .cmd_valid (rd_req_valid), .cmd_ready (rd_req_ready), .cmd (rd_req),
    .resp_valid, .resp_ready, .resp_data
  );

  axil_sram_wr u_wr (
    .clk, .rst_n, .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .cmd_valid (wr_req_valid), .cmd_ready (wr_req_ready), .cmd (wr_req)
  );

  // single memory port shared by both adapters
  sram_port_arb u_arb (
    .clk, .rst_n,
    .rd_valid (rd_req_valid), .rd_ready (rd_req_ready), .rd_cmd (rd_req),
    .wr_valid (wr_req_valid), .wr_ready (wr_req_ready), .wr_cmd (wr_req),
    .mem_valid (mem_req_valid), .mem_ready (mem_req_ready), .mem_cmd (mem_req)
  );

  sram_mem u_mem (
    .clk, .rst_n,
    .cmd_valid (mem_req_valid), .cmd_ready (mem_req_ready), .cmd (mem_req),
    .resp_valid, .resp_ready, .resp_data  // reads only, straight to u_rd
  );

endmodule

`default_nettype wire

//--- hw/axil_sram_wr.sv
`default_nettype none
`timescale 1ns/1ps

module axil_sram_wr (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      awvalid,
  output logic                      awready,
  input  axil_sram_pkg::axil_addr_t awaddr,

  input  logic                      wvalid,
  output logic                      wready,
  input  axil_sram_pkg::axil_data_t wdata,
  input  axil_sram_pkg::axil_strb_t wstrb,

  output logic                      bvalid,
  input  logic                      bready,
  output axil_sram_pkg::axil_resp_t bresp,

  output logic                      cmd_valid,
  input  logic                      cmd_ready,
  output axil_sram_pkg::sram_cmd_t  cmd
);
  import axil_sram_pkg::*;

  wr_state_t state;
  sram_cmd_t cmd_q;
  logic      take;  // AW and W move together

  assign take    = (state == wr_idle) && awvalid && wvalid;
  assign awready = take;
  assign wready  = take;

  // ======================================
  // control
  // ======================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= wr_idle;
      bvalid <= 1'b0;
    end else begin
      case (state)
        wr_idle: begin
          if (take) state <= wr_cmd;
        end
        wr_cmd: begin
          if (cmd_ready) state <= wr_bresp;
        end
        wr_bresp: begin
          bvalid <= 1'b1;  // one edge after the memory took it
          state  <= wr_done;
        end
        wr_done: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= wr_idle;
          end
        end
        default: state <= wr_idle;
      endcase
    end
  end

  // command payload
  always_ff @(posedge clk) begin
    if (take) begin
      cmd_q.we    <= 1'b1;
      cmd_q.addr  <= awaddr[axil_addr_w-1:addr_lsb];
      cmd_q.wdata <= wdata;
      cmd_q.wstrb <= wstrb;
    end
  end

  assign cmd_valid = (state == wr_cmd);
  assign cmd       = cmd_q;
  assign bresp     = resp_okay;

  // B may only open once the write has left for the memory
  a_b_after_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(bvalid) |-> !cmd_valid && $past(!cmd_valid));

endmodule

`default_nettype wire

//--- hw/sram_mem.sv
`default_nettype none
`timescale 1ns/1ps

module sram_mem (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      cmd_valid,
  output logic                      cmd_ready,
  input  axil_sram_pkg::sram_cmd_t  cmd,

  output logic                      resp_valid,
  input  logic                      resp_ready,
  output axil_sram_pkg::axil_data_t resp_data
);
  import axil_sram_pkg::*;

  axil_data_t mem [sram_depth];
  logic       accept;

  // stall while a read result waits on the R side
  assign cmd_ready = !resp_valid || resp_ready;
  assign accept    = cmd_valid && cmd_ready;

  // ======================================
  // array
  // ======================================
  always_ff @(posedge clk) begin
    if (accept && cmd.we) begin
      for (int b = 0; b < $bits(axil_strb_t); b++) begin
        if (cmd.wstrb[b]) begin
          mem[cmd.addr][b*8 +: 8] <= cmd.wdata[b*8 +: 8];
        end
      end
    end
  end

  // ======================================
  // read response register
  // ======================================
  always_ff @(posedge clk) begin
    if (accept && !cmd.we) resp_data <= mem[cmd.addr];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (accept && !cmd.we) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;  // drained
    end
  end

  a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_data));

endmodule

`default_nettype wire

//--- hw/sram_port_arb.sv
`default_nettype none
`timescale 1ns/1ps

module sram_port_arb (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     rd_valid,
  output logic                     rd_ready,
  input  axil_sram_pkg::sram_cmd_t rd_cmd,

  input  logic                     wr_valid,
  output logic                     wr_ready,
  input  axil_sram_pkg::sram_cmd_t wr_cmd,

  output logic                     mem_valid,
  input  logic                     mem_ready,
  output axil_sram_pkg::sram_cmd_t mem_cmd
);

  logic prio_wr;  // write side wins a tie
  logic locked;   // grant held until accepted
  logic lock_wr;
  logic sel_wr;

  // ======================================
  // grant select
  // ======================================
  always_comb begin
    if (locked) begin
      sel_wr = lock_wr;
    end else if (rd_valid && wr_valid) begin
      sel_wr = prio_wr;
    end else begin
      sel_wr = wr_valid;
    end
  end

  assign mem_valid = sel_wr ? wr_valid : rd_valid;
  assign mem_cmd   = sel_wr ? wr_cmd : rd_cmd;
  assign rd_ready  = !sel_wr && mem_ready;
  assign wr_ready  = sel_wr && mem_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prio_wr <= 1'b0;
      locked  <= 1'b0;
      lock_wr <= 1'b0;
    end else if (mem_valid) begin
      if (mem_ready) begin
        locked  <= 1'b0;
        prio_wr <= !sel_wr;  // other side goes first next time
      end else begin
        locked  <= 1'b1;
        lock_wr <= sel_wr;
      end
    end
  end

  // only one adapter is ever handed the port
  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_ready && wr_ready));

endmodule

`default_nettype wire

//--- sim/axil_sram_tb_util.svh
`default_nettype none

  // ======================================
  // random numbers
  // ======================================
  logic [31:0] rng_state = 32'd87;
  int          error_count = 0;

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // ======================================
  // checks
  // ======================================
  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input axil_data_t got, input axil_data_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_resp(input axil_resp_t got, input axil_resp_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

`default_nettype wire

//--- sim/axil_sram_tb.sv
`default_nettype none
`timescale 1ns/1ps

module axil_sram_tb;
  import axil_sram_pkg::*;

  localparam int n_fill = 200;
  localparam int n_strb = 50;
  localparam int n_odd  = 20;
  localparam int n_pair = 50;
  localparam int n_txn  = 2*n_fill + 3*n_strb + 2*n_odd + 4*n_pair + 4;
  localparam int max_cycles = 40*n_txn + 100;

  logic       clk, rst_n;
  logic       arvalid, arready, rvalid, rready;
  logic       awvalid, awready, wvalid, wready, bvalid, bready;
  axil_addr_t araddr, awaddr;
  axil_data_t rdata, wdata;
  axil_strb_t wstrb;
  axil_resp_t rresp, bresp;

  axil_data_t model [sram_addr_t];    // expected word contents
  axil_strb_t written [sram_addr_t];  // bytes written so far
  int         cycle_count = 0;

  `include "axil_sram_tb_util.svh"

  axil_sram_top uut (
    .clk, .rst_n, .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      stop_run();
    end
  end

  task automatic model_write(input sram_addr_t w, input axil_data_t d, input axil_strb_t s);
    axil_data_t cur;
    int         b;
    cur = model.exists(w) ? model[w] : '0;
    for (b = 0; b < 2; b++) begin
      if (s[b]) cur[b*8 +: 8] = d[b*8 +: 8];
    end
    model[w]   = cur;
    written[w] = (written.exists(w) ? written[w] : 2'b00) | s;
  endtask

  // ======================================
  // bus tasks, entered on a falling edge
  // ======================================
  task automatic write_beats(input axil_addr_t a, input axil_data_t d, input axil_strb_t s);
    awvalid = 1'b1;
    awaddr  = a;
    wvalid  = 1'b1;
    wdata   = d;
    wstrb   = s;
    do @(posedge clk); while (!(awready && wready));
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic write_reply(input int stall, output axil_resp_t r);
    repeat (stall) @(negedge clk);
    bready = 1'b1;
    do @(posedge clk); while (!bvalid);
    r = bresp;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input axil_addr_t a, input int stall,
                          output axil_data_t d, output axil_resp_t r);
    arvalid = 1'b1;
    araddr  = a;
    do @(posedge clk); while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    repeat (stall) @(negedge clk);  // rready held low
    rready = 1'b1;
    do @(posedge clk); while (!rvalid);
    d = rdata;
    r = rresp;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic write_checked(input sram_addr_t w, input axil_data_t d, input axil_strb_t s);
    axil_resp_t r;
    write_beats({w, 1'b0}, d, s);
    write_reply(int'(next_rand() % 4), r);
    check_resp(r, resp_okay, "bresp");
    model_write(w, d, s);
  endtask

  task automatic read_checked(input axil_addr_t a);
    sram_addr_t w;
    axil_data_t d;
    axil_resp_t r;
    w = sram_addr_t'(a >> 1);  // byte offset ignored
    if (!written.exists(w) || written[w] != 2'b11) begin
      $display("test sequence error: word %h read before it was fully written", w);
      stop_run();
    end
    axi_read(a, int'(next_rand() % 4), d, r);
    check_data(d, model[w], $sformatf("rdata at %h", a));
    check_resp(r, resp_okay, "rresp");
  endtask

  // ======================================
  // test sequence
  // ======================================
  initial begin
    sram_addr_t addrs[$];
    sram_addr_t w, wa;
    axil_data_t d, got_d;
    axil_resp_t got_r, got_b;
    int         rs, bs;
    rst_n   = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    repeat (5) @(negedge clk);
    check_flag(arready, 1'b0, "arready out of reset");
    check_flag(awready, 1'b0, "awready out of reset");
    check_flag(wready, 1'b0, "wready out of reset");
    check_flag(rvalid, 1'b0, "rvalid out of reset");
    check_flag(bvalid, 1'b0, "bvalid out of reset");
    rst_n = 1'b1;

    for (int i = 0; i < n_fill; i++) begin
      w = sram_addr_t'(next_rand());
      addrs.push_back(w);
      write_checked(w, axil_data_t'(next_rand()), 2'b11);
    end
    foreach (addrs[i]) read_checked({addrs[i], 1'b0});

    for (int i = 0; i < n_strb; i++) begin  // partial strobes
      w = sram_addr_t'(next_rand());
      write_checked(w, axil_data_t'(next_rand()), 2'b11);
      write_checked(w, axil_data_t'(next_rand()), axil_strb_t'(next_rand()));
      read_checked({w, 1'b0});
    end

    for (int i = 0; i < n_odd; i++) begin
      w = sram_addr_t'(next_rand());
      write_checked(w, axil_data_t'(next_rand()), 2'b11);
      read_checked({w, 1'b1});  // odd byte address, same word
    end

    // read and write launched on the same edge
    for (int i = 0; i < n_pair; i++) begin
      w  = sram_addr_t'(next_rand());
      wa = w + sram_addr_t'(1 + next_rand() % 1000);  // never the same word
      write_checked(w, axil_data_t'(next_rand()), 2'b11);
      d  = axil_data_t'(next_rand());
      rs = int'(next_rand() % 4);
      bs = int'(next_rand() % 4);
      fork
        axi_read({w, 1'b0}, rs, got_d, got_r);
        begin
          write_beats({wa, 1'b0}, d, 2'b11);
          write_reply(bs, got_b);
        end
      join
      check_data(got_d, model[w], "rdata racing a write");
      check_resp(got_r, resp_okay, "rresp racing a write");
      check_resp(got_b, resp_okay, "bresp racing a read");
      model_write(wa, d, 2'b11);
      read_checked({wa, 1'b0});
    end

    // B held off while a read goes through
    w  = sram_addr_t'(next_rand());
    wa = w ^ 11'h400;
    d  = axil_data_t'(next_rand());
    write_checked(w, axil_data_t'(next_rand()), 2'b11);
    write_beats({wa, 1'b0}, d, 2'b11);
    while (!bvalid) @(negedge clk);
    read_checked({w, 1'b0});
    check_flag(bvalid, 1'b1, "bvalid held across the read");
    write_reply(0, got_b);
    check_resp(got_b, resp_okay, "held bresp");
    model_write(wa, d, 2'b11);
    read_checked({wa, 1'b0});

    if (error_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

`default_nettype wire

//--- src.f
hw/axil_sram_pkg.sv
hw/axil_sram_rd.sv
hw/axil_sram_wr.sv
hw/sram_port_arb.sv
hw/sram_mem.sv
hw/axil_sram_top.sv
+incdir+sim
sim/axil_sram_tb.sv
